// ==== logic/llc_pkg.sv ====
`default_nettype none

package llc_pkg;

    localparam int llc_set_bits  = 6;
    localparam int llc_ways      = 4;
    localparam int llc_bank_bits = 1;
    localparam int llc_tag_bits  = 16;
    localparam int line_bits     = 128;

    typedef logic [llc_set_bits-1:0]     llc_set_t;
    typedef logic [$clog2(llc_ways)-1:0] llc_way_t;
    typedef logic [llc_tag_bits-1:0]     llc_tag_t;
    typedef logic [line_bits-1:0]        line_t;

    // invalid must stay zero, the init sweep writes all-zero metadata
    typedef enum logic [1:0] {
        llc_invalid  = 2'd0,
        llc_valid    = 2'd1,
        llc_shared   = 2'd2,
        llc_modified = 2'd3
    } llc_state_t;

    typedef struct packed {
        llc_tag_t   tag;
        llc_state_t state;
        logic       dirty;
        logic       hprot;
        logic [3:0] owner;
        logic [7:0] sharers;
    } llc_meta_t;

    typedef enum logic {
        llc_op_lookup = 1'b0,
        llc_op_fill   = 1'b1
    } llc_op_t;

    typedef struct packed {
        llc_op_t   op;
        llc_set_t  set;
        llc_tag_t  tag;
        line_t     line;
        llc_meta_t meta;
    } llc_req_t;

    typedef struct packed {
        logic      hit;
        llc_way_t  way;
        line_t     line;
        llc_meta_t meta;
        logic      evicted;
        llc_meta_t victim_meta;
    } llc_rsp_t;

endpackage

`default_nettype wire

// ==== logic/llc_bram.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_bram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] a_addr,
    input  logic [$clog2(DEPTH)-1:0] b_addr,
    input  logic                     a_en,
    input  logic                     b_en,
    input  logic                     a_we,
    input  logic                     b_we,
    input  logic [WIDTH-1:0]         a_din,
    input  logic [WIDTH-1:0]         b_din,
    output logic [WIDTH-1:0]         a_dout,
    output logic [WIDTH-1:0]         b_dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // read-first on both ports
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_dout <= mem[a_addr];
            if (a_we) begin
                mem[a_addr] <= a_din;
            end
        end
        if (b_en) begin
            b_dout <= mem[b_addr];
            if (b_we) begin
                mem[b_addr] <= b_din;
            end
        end
    end

    // the two ports must never collide on a write
    assert property (@(posedge clk)
        !(a_en && a_we && b_en && b_we && (a_addr == b_addr)))
        else $error("llc_bram: both ports write address %0d", a_addr);

endmodule

`default_nettype wire

// ==== logic/llc_localmem.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_localmem import llc_pkg::*; #(
    parameter int SET_BITS  = llc_set_bits,
    parameter int WAYS      = llc_ways,
    parameter int BANK_BITS = llc_bank_bits
) (
    input  logic                 clk,
    input  logic                 rd_en,
    input  llc_set_t             set,
    input  logic                 wr_en,
    input  llc_way_t             wr_way,
    input  llc_meta_t            wr_meta,
    input  line_t                wr_line,
    input  logic                 evict_wr_en,
    input  llc_way_t             evict_wr_data,
    output llc_meta_t [WAYS-1:0] rd_meta,
    output line_t [WAYS-1:0]     rd_line,
    output llc_way_t             rd_evict_way
);

    localparam int BANKS      = 1 << BANK_BITS;
    localparam int INDEX_BITS = SET_BITS - BANK_BITS;
    localparam int BANK_DEPTH = 1 << INDEX_BITS;

    logic [INDEX_BITS-1:0]      index;
    logic [BANK_BITS:0]         bank;
    logic [BANK_BITS:0]         rd_bank_q;
    logic [BANKS-1:0]           bank_sel;
    logic [BANKS-1:0]           evict_we;
    logic [WAYS-1:0][BANKS-1:0] we;
    logic                       clear_set;

    llc_meta_t meta_q [WAYS][BANKS];
    line_t     line_q [WAYS][BANKS];
    llc_way_t  evict_q [BANKS];

    assign index = set[INDEX_BITS-1:0];
    assign bank  = (BANK_BITS + 1)'(set[SET_BITS-1:0] >> INDEX_BITS);

    // a pointer write with no line write clears every way of the set
    assign clear_set = evict_wr_en && !wr_en;

    always_comb begin
        for (int k = 0; k < BANKS; k++) begin
            bank_sel[k] = (bank == (BANK_BITS + 1)'(k));
            evict_we[k] = evict_wr_en && bank_sel[k];
            for (int w = 0; w < WAYS; w++) begin
                we[w][k] = bank_sel[k] &&
                           (clear_set || (wr_en && (wr_way == llc_way_t'(w))));
            end
        end
    end

    // bank of the outstanding read, for the output mux
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bank_q <= bank;
        end
    end

    // even way on port a, odd way on port b, top address bit splits them
    for (genvar p = 0; p < WAYS / 2; p++) begin : g_pair
        for (genvar k = 0; k < BANKS; k++) begin : g_bank
            llc_bram #(
                .WIDTH($bits(llc_meta_t)),
                .DEPTH(2 * BANK_DEPTH)
            ) meta_ram (
                .clk   (clk),
                .a_addr({1'b0, index}),
                .b_addr({1'b1, index}),
                .a_en  (rd_en | we[2*p][k]),
                .b_en  (rd_en | we[2*p+1][k]),
                .a_we  (we[2*p][k]),
                .b_we  (we[2*p+1][k]),
                .a_din (wr_meta),
                .b_din (wr_meta),
                .a_dout(meta_q[2*p][k]),
                .b_dout(meta_q[2*p+1][k])
            );

            llc_bram #(
                .WIDTH($bits(line_t)),
                .DEPTH(2 * BANK_DEPTH)
            ) line_ram (
                .clk   (clk),
                .a_addr({1'b0, index}),
                .b_addr({1'b1, index}),
                .a_en  (rd_en | we[2*p][k]),
                .b_en  (rd_en | we[2*p+1][k]),
                .a_we  (we[2*p][k]),
                .b_we  (we[2*p+1][k]),
                .a_din (wr_line),
                .b_din (wr_line),
                .a_dout(line_q[2*p][k]),
                .b_dout(line_q[2*p+1][k])
            );
        end
    end

    // one pointer per set, port b idle
    for (genvar k = 0; k < BANKS; k++) begin : g_evict
        llc_bram #(
            .WIDTH($bits(llc_way_t)),
            .DEPTH(BANK_DEPTH)
        ) evict_ram (
            .clk   (clk),
            .a_addr(index),
            .b_addr('0),
            .a_en  (rd_en | evict_we[k]),
            .b_en  (1'b0),
            .a_we  (evict_we[k]),
            .b_we  (1'b0),
            .a_din (evict_wr_data),
            .b_din ('0),
            .a_dout(evict_q[k]),
            .b_dout()
        );
    end

    always_comb begin
        rd_meta      = '0;
        rd_line      = '0;
        rd_evict_way = '0;
        for (int k = 0; k < BANKS; k++) begin
            if (rd_bank_q == (BANK_BITS + 1)'(k)) begin
                for (int w = 0; w < WAYS; w++) begin
                    rd_meta[w] = meta_q[w][k];
                    rd_line[w] = line_q[w][k];
                end
                rd_evict_way = evict_q[k];
            end
        end
    end

    // a line write lands in exactly one way of one bank
    assert property (@(posedge clk) wr_en |-> $onehot0(we))
        else $error("llc_localmem: write enables not one-hot, %b", we);

endmodule

`default_nettype wire

// ==== logic/llc_way_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_way_select import llc_pkg::*; #(
    parameter int WAYS = llc_ways
) (
    input  llc_meta_t [WAYS-1:0] rd_meta,
    input  llc_tag_t             tag,
    input  llc_way_t             rd_evict_way,
    output logic                 hit,
    output llc_way_t             hit_way,
    output llc_way_t             target_way
);

    logic [WAYS-1:0] way_hit;

    // only a live line can match
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = (rd_meta[w].state != llc_invalid) &&
                         (rd_meta[w].tag == tag);
        end
    end

    // lowest matching way wins
    always_comb begin
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = llc_way_t'(w);
            end
        end
    end

    assign hit = |way_hit;

    // miss goes to the way under the round-robin pointer
    assign target_way = hit ? hit_way : rd_evict_way;

    // fills overwrite on a hit, so a tag lives in one way of a set only
    always_comb begin
        assert ($onehot0(way_hit))
            else $error("llc_way_select: tag %h hits in ways %b", tag, way_hit);
    end

endmodule

`default_nettype wire

// ==== logic/llc_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_ctrl import llc_pkg::*; #(
    parameter int SET_BITS = llc_set_bits,
    parameter int WAYS     = llc_ways
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  llc_req_t             req_data,
    output logic                 ack,
    output llc_rsp_t             rsp,
    output logic                 rd_en,
    output llc_set_t             set,
    output logic                 wr_en,
    output llc_way_t             wr_way,
    output llc_meta_t            wr_meta,
    output line_t                wr_line,
    output logic                 evict_wr_en,
    output llc_way_t             evict_wr_data,
    input  llc_meta_t [WAYS-1:0] rd_meta,
    input  line_t [WAYS-1:0]     rd_line,
    input  logic                 hit,
    input  llc_way_t             hit_way,
    input  llc_way_t             target_way
);

    typedef enum logic [2:0] {
        st_init,
        st_idle,
        st_read,
        st_compare,
        st_write,
        st_done
    } state_t;

    state_t              state;
    logic [SET_BITS-1:0] sweep_set;
    logic                req_seen;
    llc_req_t            req_q;
    logic                hit_q;
    llc_way_t            way_q;
    llc_way_t            next_ptr;
    llc_meta_t           fill_meta;
    llc_meta_t           victim;
    logic                is_fill;

    assign is_fill = (req_q.op == llc_op_fill);
    assign victim  = rd_meta[target_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_init;
            sweep_set <= '0;
            req_seen  <= 1'b0;
            ack       <= 1'b0;
        end else begin
            // this register is the capture cycle of the handshake
            req_seen <= req;
            case (state)
                st_init: begin
                    sweep_set <= sweep_set + 1'b1;
                    if (&sweep_set) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (req_seen) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    state <= st_compare;
                end
                st_compare: begin
                    if (is_fill) begin
                        state <= st_write;
                    end else begin
                        state <= st_done;
                        ack   <= 1'b1;
                    end
                end
                st_write: begin
                    state <= st_done;
                    ack   <= 1'b1;
                end
                st_done: begin
                    if (!req_seen) begin
                        state <= st_idle;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= st_init;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req_seen) begin
            req_q <= req_data;
        end
        if (state == st_compare) begin
            hit_q           <= hit;
            way_q           <= target_way;
            rsp.hit         <= hit;
            rsp.way         <= is_fill ? target_way : hit_way;
            rsp.line        <= hit ? rd_line[hit_way] : '0;
            rsp.meta        <= hit ? rd_meta[hit_way] : '0;
            rsp.evicted     <= is_fill && !hit && (victim.state != llc_invalid);
            rsp.victim_meta <= (is_fill && !hit) ? victim : '0;
        end
    end

    // stored tag always comes from the request
    always_comb begin
        fill_meta     = req_q.meta;
        fill_meta.tag = req_q.tag;
    end

    assign next_ptr = (way_q == llc_way_t'(WAYS - 1)) ? '0 : way_q + 1'b1;

    assign rd_en         = (state == st_read);
    assign set           = (state == st_init) ? llc_set_t'(sweep_set) : req_q.set;
    assign wr_en         = (state == st_write);
    assign wr_way        = way_q;
    assign wr_meta       = (state == st_init) ? '0 : fill_meta;
    assign wr_line       = (state == st_init) ? '0 : req_q.line;
    assign evict_wr_en   = (state == st_init) || ((state == st_write) && !hit_q);
    assign evict_wr_data = (state == st_init) ? '0 : next_ptr;

    // ack only answers a request that was up on the previous edge
    assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
        else $error("llc_ctrl: ack rose without a request");

endmodule

`default_nettype wire

// ==== logic/llc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_top import llc_pkg::*; #(
    parameter int SET_BITS  = llc_set_bits,
    parameter int WAYS      = llc_ways,
    parameter int BANK_BITS = llc_bank_bits
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  llc_req_t req_data,
    output logic     ack,
    output llc_rsp_t rsp
);

    logic                 rd_en;
    llc_set_t             set;
    logic                 wr_en;
    llc_way_t             wr_way;
    llc_meta_t            wr_meta;
    line_t                wr_line;
    logic                 evict_wr_en;
    llc_way_t             evict_wr_data;
    llc_meta_t [WAYS-1:0] rd_meta;
    line_t [WAYS-1:0]     rd_line;
    llc_way_t             rd_evict_way;
    logic                 hit;
    llc_way_t             hit_way;
    llc_way_t             target_way;

    llc_ctrl #(
        .SET_BITS(SET_BITS),
        .WAYS    (WAYS)
    ) ctrl (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_data     (req_data),
        .ack          (ack),
        .rsp          (rsp),
        .rd_en        (rd_en),
        .set          (set),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_meta      (wr_meta),
        .wr_line      (wr_line),
        .evict_wr_en  (evict_wr_en),
        .evict_wr_data(evict_wr_data),
        .rd_meta      (rd_meta),
        .rd_line      (rd_line),
        .hit          (hit),
        .hit_way      (hit_way),
        .target_way   (target_way)
    );

    llc_localmem #(
        .SET_BITS (SET_BITS),
        .WAYS     (WAYS),
        .BANK_BITS(BANK_BITS)
    ) localmem (
        .clk          (clk),
        .rd_en        (rd_en),
        .set          (set),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_meta      (wr_meta),
        .wr_line      (wr_line),
        .evict_wr_en  (evict_wr_en),
        .evict_wr_data(evict_wr_data),
        .rd_meta      (rd_meta),
        .rd_line      (rd_line),
        .rd_evict_way (rd_evict_way)
    );

    // request data is held stable until ack, so its tag is valid in compare
    llc_way_select #(
        .WAYS(WAYS)
    ) way_select (
        .rd_meta     (rd_meta),
        .tag         (req_data.tag),
        .rd_evict_way(rd_evict_way),
        .hit         (hit),
        .hit_way     (hit_way),
        .target_way  (target_way)
    );

endmodule

`default_nettype wire

// ==== tests/llc_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_checker import llc_pkg::*; #(
    parameter int SET_BITS = llc_set_bits,
    parameter int WAYS     = llc_ways
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  llc_req_t req_data,
    input  logic     ack,
    input  llc_rsp_t rsp,
    input  logic     exp_hit,
    input  llc_way_t exp_way,
    input  logic     exp_evicted,
    output int       errors,
    output int       checks
);

    localparam int SETS           = 1 << SET_BITS;
    localparam int LOOKUP_LATENCY = 3;
    localparam int FILL_LATENCY   = 4;

    llc_meta_t model_meta [SETS][WAYS];
    line_t     model_line [SETS][WAYS];
    int        model_ptr  [SETS];

    llc_req_t cur;
    llc_rsp_t held;
    logic     req_q;
    logic     ack_q;
    logic     first;
    int       cycle;
    int       req_cycle;
    int       drop_cycle;
    int       latency;

    // the sweep leaves every way invalid and every pointer at way 0
    initial begin
        errors = 0;
        checks = 0;
        for (int s = 0; s < SETS; s++) begin
            model_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                model_meta[s][w] = '0;
                model_line[s][w] = '0;
            end
        end
    end

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error: %s is %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_response();
        logic      hit;
        logic      evicted;
        int        way;
        llc_meta_t stored;
        hit     = 1'b0;
        evicted = 1'b0;
        way     = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_meta[cur.set][w].state != llc_invalid &&
                model_meta[cur.set][w].tag == cur.tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        // a fill miss replaces the way under the set's pointer
        if (cur.op == llc_op_fill && !hit) begin
            way     = model_ptr[cur.set];
            evicted = (model_meta[cur.set][way].state != llc_invalid);
        end
        compare_value("rsp.hit", rsp.hit, hit);
        compare_value("rsp.hit (table)", rsp.hit, exp_hit);
        compare_value("rsp.evicted", rsp.evicted, evicted);
        compare_value("rsp.evicted (table)", rsp.evicted, exp_evicted);
        if (hit || cur.op == llc_op_fill) begin
            compare_value("rsp.way", rsp.way, way);
            compare_value("rsp.way (table)", rsp.way, exp_way);
        end
        if (hit) begin
            compare_value("rsp.line", rsp.line, model_line[cur.set][way]);
            compare_value("rsp.meta", rsp.meta, model_meta[cur.set][way]);
        end
        if (evicted) begin
            compare_value("rsp.victim_meta", rsp.victim_meta, model_meta[cur.set][way]);
        end
        if (cur.op == llc_op_fill) begin
            stored     = cur.meta;
            stored.tag = cur.tag;
            model_meta[cur.set][way] = stored;
            model_line[cur.set][way] = cur.line;
            if (!hit) begin
                model_ptr[cur.set] = (model_ptr[cur.set] + 1) % WAYS;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            req_q = 1'b0;
            ack_q = 1'b0;
            first = 1'b1;
            cycle = 0;
        end else begin
            cycle++;
            if (req && !req_q) begin
                cur       = req_data;
                req_cycle = cycle;
            end
            if (!req && req_q) begin
                drop_cycle = cycle;
            end
            if (ack && !ack_q) begin
                check_response();
                held = rsp;
                checks++;
                // ack is seen here one edge after the DUT registers it
                latency = (cur.op == llc_op_fill) ? FILL_LATENCY : LOOKUP_LATENCY;
                if (first) begin
                    first = 1'b0;
                    if (cycle <= SETS) begin
                        errors++;
                        $display("first request answered before the init sweep ended");
                    end
                end else if (cycle - req_cycle != latency + 1) begin
                    errors++;
                    $display("ack came %0d cycles after req, expected %0d at %0t",
                             cycle - req_cycle - 1, latency, $time);
                end
            end else if (ack && req && rsp !== held) begin
                errors++;
                $display("rsp changed while req was held high at %0t", $time);
            end
            if (!ack && ack_q) begin
                checks++;
                if (req) begin
                    errors++;
                    $display("ack fell while req was still high at %0t", $time);
                end else if (cycle - drop_cycle != 2) begin
                    errors++;
                    $display("ack fell %0d cycles after req fell at %0t",
                             cycle - drop_cycle - 1, $time);
                end
            end
            req_q = req;
            ack_q = ack;
        end
    end

endmodule

`default_nettype wire

// ==== tests/llc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module llc_tb import llc_pkg::*; ();

    localparam int PERIOD          = 40;
    localparam int RESET_CYCLES    = 8;
    localparam int SWEEP_CYCLES    = 1 << llc_set_bits;
    localparam int STEPS           = 24;
    // room per request for the handshake, hold cycles and the gap after it
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SWEEP_CYCLES + STEPS * 20;

    typedef struct packed {
        llc_op_t    op;
        llc_set_t   set;
        llc_tag_t   tag;
        llc_state_t state;
        logic       dirty;
        logic [2:0] hold;
        logic       hit;
        llc_way_t   way;
        logic       evicted;
    } step_t;

    logic     clk;
    logic     reset;
    logic     req;
    llc_req_t req_data;
    logic     ack;
    llc_rsp_t rsp;
    logic     exp_hit;
    llc_way_t exp_way;
    logic     exp_evicted;
    int       errors;
    int       checks;
    step_t    steps [STEPS];

    llc_top #(
        .SET_BITS (llc_set_bits),
        .WAYS     (llc_ways),
        .BANK_BITS(llc_bank_bits)
    ) DUT (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .req_data(req_data),
        .ack     (ack),
        .rsp     (rsp)
    );

    llc_checker #(
        .SET_BITS(llc_set_bits),
        .WAYS    (llc_ways)
    ) monitor (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .rsp        (rsp),
        .exp_hit    (exp_hit),
        .exp_way    (exp_way),
        .exp_evicted(exp_evicted),
        .errors     (errors),
        .checks     (checks)
    );

    function automatic step_t make_step(llc_op_t op, int set, llc_tag_t tag,
                                        llc_state_t state, logic dirty, int hold,
                                        logic hit, int way, logic evicted);
        step_t s;
        s.op      = op;
        s.set     = llc_set_t'(set);
        s.tag     = tag;
        s.state   = state;
        s.dirty   = dirty;
        s.hold    = 3'(hold);
        s.hit     = hit;
        s.way     = llc_way_t'(way);
        s.evicted = evicted;
        return s;
    endfunction

    // sets 5 and 37 differ only in the bank bit, as do 31 and 63
    task automatic load_steps();
        // op, set, tag, state, dirty, hold, hit, way, evicted
        steps[0]  = make_step(llc_op_lookup, 0, 16'h0000, llc_invalid, 0, 2, 0, 0, 0);
        steps[1]  = make_step(llc_op_lookup, 37, 16'h1234, llc_invalid, 0, 0, 0, 0, 0);
        steps[2]  = make_step(llc_op_lookup, 63, 16'hffff, llc_invalid, 0, 0, 0, 0, 0);
        steps[3]  = make_step(llc_op_fill, 5, 16'ha001, llc_modified, 1, 0, 0, 0, 0);
        steps[4]  = make_step(llc_op_lookup, 5, 16'ha001, llc_invalid, 0, 3, 1, 0, 0);
        steps[5]  = make_step(llc_op_fill, 5, 16'ha002, llc_modified, 1, 0, 0, 1, 0);
        steps[6]  = make_step(llc_op_fill, 5, 16'ha003, llc_shared, 0, 0, 0, 2, 0);
        steps[7]  = make_step(llc_op_fill, 5, 16'ha004, llc_valid, 0, 0, 0, 3, 0);
        steps[8]  = make_step(llc_op_fill, 5, 16'ha005, llc_valid, 0, 1, 0, 0, 1);
        steps[9]  = make_step(llc_op_lookup, 5, 16'ha001, llc_invalid, 0, 0, 0, 0, 0);
        steps[10] = make_step(llc_op_lookup, 5, 16'ha003, llc_invalid, 0, 0, 1, 2, 0);
        steps[11] = make_step(llc_op_fill, 5, 16'ha003, llc_modified, 1, 2, 1, 2, 0);
        steps[12] = make_step(llc_op_lookup, 5, 16'ha003, llc_invalid, 0, 0, 1, 2, 0);
        steps[13] = make_step(llc_op_fill, 5, 16'ha006, llc_valid, 0, 0, 0, 1, 1);
        steps[14] = make_step(llc_op_fill, 37, 16'ha001, llc_valid, 0, 0, 0, 0, 0);
        steps[15] = make_step(llc_op_lookup, 37, 16'ha001, llc_invalid, 0, 0, 1, 0, 0);
        steps[16] = make_step(llc_op_lookup, 5, 16'ha005, llc_invalid, 0, 0, 1, 0, 0);
        steps[17] = make_step(llc_op_fill, 37, 16'hb002, llc_shared, 0, 0, 0, 1, 0);
        steps[18] = make_step(llc_op_lookup, 37, 16'hb002, llc_invalid, 0, 4, 1, 1, 0);
        steps[19] = make_step(llc_op_lookup, 37, 16'ha001, llc_invalid, 0, 0, 1, 0, 0);
        steps[20] = make_step(llc_op_fill, 63, 16'hc000, llc_modified, 1, 0, 0, 0, 0);
        steps[21] = make_step(llc_op_lookup, 31, 16'hc000, llc_invalid, 0, 0, 0, 0, 0);
        steps[22] = make_step(llc_op_lookup, 63, 16'hc000, llc_invalid, 0, 0, 1, 0, 0);
        steps[23] = make_step(llc_op_lookup, 5, 16'ha004, llc_invalid, 0, 0, 1, 3, 0);
    endtask

    // one four-phase handshake, entered and left on a rising edge
    task automatic run_request(input step_t s);
        llc_req_t r;
        r.op           = s.op;
        r.set          = s.set;
        r.tag          = s.tag;
        r.line         = {$urandom, $urandom, $urandom, $urandom};
        // stored tag has to come from the request tag, not from this field
        r.meta.tag     = ~s.tag;
        r.meta.state   = s.state;
        r.meta.dirty   = s.dirty;
        r.meta.hprot   = s.dirty;
        r.meta.owner   = s.tag[3:0];
        r.meta.sharers = s.tag[15:8];
        req         <= 1'b1;
        req_data    <= r;
        exp_hit     <= s.hit;
        exp_way     <= s.way;
        exp_evicted <= s.evicted;
        do @(posedge clk); while (!ack);
        repeat (s.hold) @(posedge clk);
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'hdab9_ddee));
        reset       = 1'b1;
        req         = 1'b0;
        req_data    = '0;
        exp_hit     = 1'b0;
        exp_way     = '0;
        exp_evicted = 1'b0;
        load_steps();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // first request goes up while the init sweep is still running
        for (int i = 0; i < STEPS; i++) begin
            run_request(steps[i]);
        end
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/llc_pkg.sv
logic/llc_bram.sv
logic/llc_localmem.sv
logic/llc_way_select.sv
logic/llc_ctrl.sv
logic/llc_top.sv
tests/llc_checker.sv
tests/llc_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the llc testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module llc_tb -f filelist.f \
    --Mdir "$build_dir" -o llc_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$build_dir/llc_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$log"; then
    exit 1
fi
exit 0
